// ==== build.f ====
+incdir+tb
logic/doa_pkg.sv
logic/doa_apb_regs.sv
logic/centrosym_front.sv
logic/bin_accumulator.sv
logic/cov_collector.sv
logic/doa_cov_top.sv
tb/doa_tb.sv

// ==== logic/bin_accumulator.sv ====
// One accumulator lane: keeps a running sum per bin and emits it on the last frame of a period.
`default_nettype none
`timescale 1ns/1ps

module bin_accumulator #(
    parameter int VECTOR_LEN = 64
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire doa_pkg::prod_t  prod,
    input  wire doa_pkg::bin_t   bin,
    input  wire                  first_frame,
    input  wire                  last_frame,
    input  wire                  beat_valid,
    output doa_pkg::acc_t        lane_sum,
    output doa_pkg::bin_t        lane_bin,
    output logic                 lane_valid
);

    import doa_pkg::*;

    // One sum per bin. Each bin comes back VECTOR_LEN beats later, so
    // the read-modify-write below never overlaps itself.
    acc_t mem [VECTOR_LEN];

    acc_t prod_ext;
    acc_t sum_new;

    assign prod_ext = acc_t'(prod);   // Sign extend.

    always_comb begin
        if (first_frame) begin
            sum_new = prod_ext;                // Restart the period.
        end else begin
            sum_new = mem[bin] + prod_ext;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            mem[bin] <= sum_new;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_valid <= 1'b0;
        end else begin
            lane_valid <= beat_valid && last_frame;
        end
    end

    // Result held until the next emitted bin.
    always_ff @(posedge clk) begin
        if (beat_valid && last_frame) begin
            lane_sum <= sum_new;
            lane_bin <= bin;
        end
    end

endmodule

`default_nettype wire

// ==== logic/centrosym_front.sv ====
// Front pipeline: registers antenna samples, tracks accumulation periods, transforms and multiplies.
`default_nettype none
`timescale 1ns/1ps

module centrosym_front #(
    parameter int VECTOR_LEN = 64
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire doa_pkg::ant_sample_s  din,
    input  wire                        din_valid,
    input  wire                        frame_start,
    input  wire                        enable,
    input  wire doa_pkg::frames_t      acc_frames,
    output doa_pkg::prod_beat_s        beat,
    output logic                       beat_valid
);

    import doa_pkg::*;

    localparam int BIN_W = $clog2(VECTOR_LEN);

    typedef enum logic {IDLE, ACCUM} state_e;

    // Signed product of two transformed components at full product width.
    function automatic prod_t mul(input csym_t a, input csym_t b);
        return prod_t'(a) * prod_t'(b);
    endfunction

    ant_sample_s      din_r;
    logic             valid_r;
    logic             fs_r;

    state_e           state;
    state_e           nxt_state;
    frames_t          frame_cnt;
    frames_t          nxt_cnt;
    frames_t          len_r;
    frames_t          nxt_len;
    logic [BIN_W-1:0] bin_cnt;
    logic [BIN_W-1:0] cur_bin;

    csym_t            y1_re;
    csym_t            y1_im;
    csym_t            y2_re;
    csym_t            y2_im;
    bin_t             bin_s2;
    logic             first_s2;
    logic             last_s2;
    logic             valid_s2;

    prod_t [NUM_LANES-1:0] prod_c;

    // Stage 1.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
            fs_r    <= 1'b0;
        end else begin
            valid_r <= din_valid;
            fs_r    <= din_valid && frame_start;
        end
    end

    always_ff @(posedge clk) begin
        din_r <= din;
    end

    // Period tracking; only a frame start can change it.
    always_comb begin
        nxt_state = state;
        nxt_cnt   = frame_cnt;
        nxt_len   = len_r;
        if (valid_r && fs_r) begin
            if (!enable) begin
                nxt_state = IDLE;                      // Abandon the period.
            end else if (state == IDLE || frame_cnt == len_r - frames_t'(1)) begin
                nxt_state = ACCUM;                     // New period.
                nxt_cnt   = '0;
                nxt_len   = acc_frames;
            end else begin
                nxt_cnt = frame_cnt + frames_t'(1);
            end
        end
    end

    assign cur_bin = fs_r ? '0 : bin_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            frame_cnt <= '0;
            len_r     <= frames_t'(1);
            bin_cnt   <= '0;
            valid_s2  <= 1'b0;
        end else begin
            state     <= nxt_state;
            frame_cnt <= nxt_cnt;
            len_r     <= nxt_len;
            if (valid_r) begin
                bin_cnt <= (cur_bin == BIN_W'(VECTOR_LEN - 1)) ? '0 : cur_bin + 1'b1;
            end
            valid_s2 <= valid_r && (nxt_state == ACCUM);
        end
    end

    // Stage 2, centrosymmetric transform.
    always_ff @(posedge clk) begin
        y1_re    <= csym_t'(din_r.din1_re) + csym_t'(din_r.din2_re);
        y1_im    <= csym_t'(din_r.din1_im) + csym_t'(din_r.din2_im);
        y2_re    <= csym_t'(din_r.din1_im) - csym_t'(din_r.din2_im);   // -j rotates.
        y2_im    <= csym_t'(din_r.din2_re) - csym_t'(din_r.din1_re);
        bin_s2   <= bin_t'(cur_bin);
        first_s2 <= (nxt_cnt == '0);
        last_s2  <= (nxt_cnt == nxt_len - frames_t'(1));
    end

    // Stage 3, covariance products.
    always_comb begin
        prod_c[LANE_R11]    = mul(y1_re, y1_re) + mul(y1_im, y1_im);
        prod_c[LANE_R22]    = mul(y2_re, y2_re) + mul(y2_im, y2_im);
        prod_c[LANE_R12_RE] = mul(y1_re, y2_re) + mul(y1_im, y2_im);
        prod_c[LANE_R12_IM] = mul(y1_im, y2_re) - mul(y1_re, y2_im);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= valid_s2;
        end
    end

    always_ff @(posedge clk) begin
        beat.prod        <= prod_c;
        beat.bin         <= bin_s2;
        beat.first_frame <= first_s2;
        beat.last_frame  <= last_s2;
    end

endmodule

`default_nettype wire

// ==== logic/cov_collector.sv ====
// Output stage: packs the four lane sums into the covariance struct and flags the end of a period.
`default_nettype none
`timescale 1ns/1ps

module cov_collector (
    input  wire                                          clk,
    input  wire                                          rst_n,
    input  wire doa_pkg::acc_t [doa_pkg::NUM_LANES-1:0]  lane_sum,
    input  wire doa_pkg::bin_t                           lane_bin,
    input  wire                                          lane_valid,
    output doa_pkg::cov_out_s                            dout,
    output logic                                         dout_valid,
    output logic                                         acc_done
);

    import doa_pkg::*;

    // Valid and bin come from lane 0; all lanes run in lockstep.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout_valid <= 1'b0;
            acc_done   <= 1'b0;
        end else begin
            dout_valid <= lane_valid;
            acc_done   <= lane_valid && (lane_bin == LAST_BIN);   // Last bin out.
        end
    end

    always_ff @(posedge clk) begin
        if (lane_valid) begin
            dout.r11    <= lane_sum[LANE_R11];
            dout.r22    <= lane_sum[LANE_R22];
            dout.r12_re <= lane_sum[LANE_R12_RE];
            dout.r12_im <= lane_sum[LANE_R12_IM];
            dout.bin    <= lane_bin;
        end
    end

endmodule

`default_nettype wire

// ==== logic/doa_apb_regs.sv ====
// APB register bank holding enable and accumulation length, and counting completed accumulations.
`default_nettype none
`timescale 1ns/1ps

module doa_apb_regs (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire doa_pkg::apb_addr_t paddr,
    input  wire                    psel,
    input  wire                    penable,
    input  wire                    pwrite,
    input  wire doa_pkg::apb_data_t pwdata,
    output doa_pkg::apb_data_t     prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  wire                    acc_done,
    output logic                   enable,
    output doa_pkg::frames_t       acc_frames
);

    import doa_pkg::*;

    logic      access;
    logic      wr_en;
    logic      mapped;
    frames_t   wr_frames;
    done_cnt_t done_count;

    assign access = psel && penable;          // Access phase.
    assign wr_en  = access && pwrite;
    assign pready = 1'b1;                     // No wait states.

    assign mapped = (paddr == REG_CTRL) || (paddr == REG_ACC_FRAMES) ||
                    (paddr == REG_DONE_COUNT);
    assign pslverr = access && !mapped;

    // Zero is not a valid length.
    assign wr_frames = (pwdata[FRAMES_WIDTH-1:0] == '0) ? frames_t'(1) :
                       pwdata[FRAMES_WIDTH-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable     <= 1'b0;
            acc_frames <= frames_t'(1);
        end else if (wr_en) begin
            if (paddr == REG_CTRL) begin
                enable <= pwdata[0];
            end
            if (paddr == REG_ACC_FRAMES) begin
                acc_frames <= wr_frames;
            end
        end
    end

    // A write of any value clears the count.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_count <= '0;
        end else if (wr_en && paddr == REG_DONE_COUNT) begin
            done_count <= '0;
        end else if (acc_done) begin
            done_count <= done_count + 1'b1;
        end
    end

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                REG_CTRL:       prdata = apb_data_t'(enable);
                REG_ACC_FRAMES: prdata = apb_data_t'(acc_frames);
                REG_DONE_COUNT: prdata = apb_data_t'(done_count);
                default:        prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/doa_cov_top.sv ====
// Top level of the covariance front end: APB bank, transform front, four lanes and output collector.
`default_nettype none
`timescale 1ns/1ps

module doa_cov_top #(
    parameter int VECTOR_LEN = 64
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire doa_pkg::ant_sample_s  din,
    input  wire                        din_valid,
    input  wire                        frame_start,
    output doa_pkg::cov_out_s          dout,
    output logic                       dout_valid,
    input  wire doa_pkg::apb_addr_t    paddr,
    input  wire                        psel,
    input  wire                        penable,
    input  wire                        pwrite,
    input  wire doa_pkg::apb_data_t    pwdata,
    output doa_pkg::apb_data_t         prdata,
    output logic                       pready,
    output logic                       pslverr
);

    import doa_pkg::*;

    logic                  enable;
    frames_t               acc_frames;
    logic                  acc_done;
    prod_beat_s            beat;
    logic                  beat_valid;
    acc_t [NUM_LANES-1:0]  lane_sum;
    bin_t                  lane_bin [NUM_LANES];
    logic [NUM_LANES-1:0]  lane_valid;

    doa_apb_regs regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .acc_done   (acc_done),
        .enable     (enable),
        .acc_frames (acc_frames)
    );

    centrosym_front #(
        .VECTOR_LEN (VECTOR_LEN)
    ) front_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .din         (din),
        .din_valid   (din_valid),
        .frame_start (frame_start),
        .enable      (enable),
        .acc_frames  (acc_frames),
        .beat        (beat),
        .beat_valid  (beat_valid)
    );

    // One lane per covariance product.
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        bin_accumulator #(
            .VECTOR_LEN (VECTOR_LEN)
        ) lane_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .prod        (beat.prod[i]),
            .bin         (beat.bin),
            .first_frame (beat.first_frame),
            .last_frame  (beat.last_frame),
            .beat_valid  (beat_valid),
            .lane_sum    (lane_sum[i]),
            .lane_bin    (lane_bin[i]),
            .lane_valid  (lane_valid[i])
        );
    end

    cov_collector collector_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .lane_sum   (lane_sum),
        .lane_bin   (lane_bin[0]),
        .lane_valid (lane_valid[0]),
        .dout       (dout),
        .dout_valid (dout_valid),
        .acc_done   (acc_done)
    );

endmodule

`default_nettype wire

// ==== logic/doa_pkg.sv ====
// Shared types, structs and register map of the ESPRIT covariance front end, imported by every RTL block.
`default_nettype none

package doa_pkg;

    // Widths of the datapath.
    localparam int DIN_WIDTH      = 16;               // Channelizer output component.
    localparam int CSYM_WIDTH     = DIN_WIDTH + 1;    // One bit of growth from the add.
    localparam int PROD_WIDTH     = 36;
    localparam int ACC_WIDTH      = PROD_WIDTH + 8;   // Room for 255 frames.
    localparam int FRAMES_WIDTH   = 8;
    localparam int DONE_WIDTH     = 16;
    localparam int VECTOR_LEN_DEF = 64;               // Sets the bin index width.

    localparam int NUM_LANES = 4;

    // Fixed lane order of the covariance products.
    localparam int LANE_R11    = 0;
    localparam int LANE_R22    = 1;
    localparam int LANE_R12_RE = 2;
    localparam int LANE_R12_IM = 3;

    typedef logic signed [DIN_WIDTH-1:0]  sample_t;
    typedef logic signed [CSYM_WIDTH-1:0] csym_t;
    typedef logic signed [PROD_WIDTH-1:0] prod_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;
    typedef logic [$clog2(VECTOR_LEN_DEF)-1:0] bin_t;
    typedef logic [FRAMES_WIDTH-1:0] frames_t;
    typedef logic [DONE_WIDTH-1:0]   done_cnt_t;
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam bin_t LAST_BIN = bin_t'(VECTOR_LEN_DEF - 1);

    typedef struct packed {
        sample_t din1_re;
        sample_t din1_im;
        sample_t din2_re;
        sample_t din2_im;
    } ant_sample_s;

    typedef struct packed {
        prod_t [NUM_LANES-1:0] prod;   // Indexed by lane order.
        bin_t                  bin;
        logic                  first_frame;   // Lane restarts its sum.
        logic                  last_frame;    // Lane emits its sum.
    } prod_beat_s;

    typedef struct packed {
        acc_t r11;
        acc_t r22;
        acc_t r12_re;
        acc_t r12_im;
        bin_t bin;
    } cov_out_s;

    // APB register map.
    localparam apb_addr_t REG_CTRL       = 8'h00;
    localparam apb_addr_t REG_ACC_FRAMES = 8'h04;
    localparam apb_addr_t REG_DONE_COUNT = 8'h08;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the covariance front end testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing -Wno-fatal -f build.f --top-module doa_tb -o doa_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/doa_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
    echo "Simulation passed, log in $LOG"
    exit 0
fi

echo "Simulation did not pass, see $LOG"
exit 1

// ==== tb/doa_tb_ref.svh ====
// Reference model and random source of the covariance testbench, included inside the testbench top.
`ifndef DOA_TB_REF_SVH
`define DOA_TB_REF_SVH

typedef logic signed [63:0] wide_t;    // Wide enough for any expected sum.

typedef struct packed {
    wide_t r11;
    wide_t r22;
    wide_t r12_re;
    wide_t r12_im;
} cov_ref_s;

typedef struct packed {
    cov_ref_s    sums;
    logic [31:0] bin;
    logic [31:0] cyc;                  // Cycle at which dout_valid must be seen.
} expect_s;

cov_ref_s ref_sum [VECTOR_LEN];        // Running sums, one per bin.

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] v;
    v = x;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
endfunction

// Transform and covariance products of one bin sample.
// y1 = x1 + x2, y2 = -j(x1 - x2); with x1 - x2 = a + jb this is b - ja.
function automatic cov_ref_s sample_products(input ant_sample_s s);
    wide_t    y1_re;
    wide_t    y1_im;
    wide_t    y2_re;
    wide_t    y2_im;
    cov_ref_s p;
    y1_re = wide_t'(s.din1_re) + wide_t'(s.din2_re);
    y1_im = wide_t'(s.din1_im) + wide_t'(s.din2_im);
    y2_re = wide_t'(s.din1_im) - wide_t'(s.din2_im);
    y2_im = wide_t'(s.din2_re) - wide_t'(s.din1_re);
    p.r11    = y1_re * y1_re + y1_im * y1_im;
    p.r22    = y2_re * y2_re + y2_im * y2_im;
    // y1 * conj(y2).
    p.r12_re = y1_re * y2_re + y1_im * y2_im;
    p.r12_im = y1_im * y2_re - y1_re * y2_im;
    return p;
endfunction

// Restarts the bin on a first frame, else adds; returns the new sums.
function automatic cov_ref_s update_ref(input int bin, input cov_ref_s p, input logic first);
    cov_ref_s s;
    if (first) begin
        s = p;
    end else begin
        s.r11    = ref_sum[bin].r11 + p.r11;
        s.r22    = ref_sum[bin].r22 + p.r22;
        s.r12_re = ref_sum[bin].r12_re + p.r12_re;
        s.r12_im = ref_sum[bin].r12_im + p.r12_im;
    end
    ref_sum[bin] = s;
    return s;
endfunction

`endif

// ==== tb/doa_tb.sv ====
// Self-checking testbench of the covariance front end; drives APB and frames, compares every output.
`default_nettype none
`timescale 1ns/1ps

module doa_tb;

    import doa_pkg::*;

    localparam int          VECTOR_LEN    = 64;
    localparam int          CLK_HALF      = 50;
    localparam int          QUARTER       = 25;      // Sampling point inside the low phase.
    localparam int          RESET_CYCLES  = 10;
    localparam int          LATENCY       = 5;
    localparam int          DRAIN_TIMEOUT = 64;
    localparam int          SETTLE_CYCLES = 8;
    localparam logic [31:0] SEED          = 32'h1783;
    localparam int          KIND_RANDOM   = 0;
    localparam int          KIND_FULL     = 1;
    localparam sample_t     FULL_POS      = 16'h7fff;
    localparam sample_t     FULL_NEG      = 16'h8000;

    `include "doa_tb_ref.svh"

    logic        clk;
    logic        rst_n;
    ant_sample_s din;
    logic        din_valid;
    logic        frame_start;
    cov_out_s    dout;
    logic        dout_valid;
    apb_addr_t   paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] rng_state;
    int          cyc = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          cmp_errors = 0;
    int          cmp_checks = 0;
    int          out_count = 0;
    int          periods_done = 0;   // Completed periods since the last count clear.
    expect_s     exp_q [$];

    doa_cov_top #(
        .VECTOR_LEN (VECTOR_LEN)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .din         (din),
        .din_valid   (din_valid),
        .frame_start (frame_start),
        .dout        (dout),
        .dout_valid  (dout_valid),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr)
    );

    always #(CLK_HALF) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic abort_run(input string reason);
        $display("Timeout at %0t: %s", $time, reason);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Compare of one accumulated field.
    task automatic compare_sum(input string name, input acc_t got, input wide_t exp, input int bin);
        cmp_checks++;
        assert (wide_t'(got) == exp) else begin
            cmp_errors++;
            $display("ERR %0t: bin %0d %s got %0d, expected %0d", $time, bin, name, got, exp);
        end
    endtask

    // Outputs are sampled mid cycle.
    always @(negedge clk) begin
        expect_s e;
        if (rst_n === 1'b1 && dout_valid === 1'b1) begin
            out_count++;
            cmp_checks++;
            assert (exp_q.size() != 0) else begin
                cmp_errors++;
                $display("Output for bin %0d appeared at %0t while no result was expected",
                         dout.bin, $time);
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                cmp_checks++;
                assert (cyc == int'(e.cyc) && int'(dout.bin) == int'(e.bin)) else begin
                    cmp_errors++;
                    $display("ERR %0t: bin %0d at cycle %0d, expected bin %0d at cycle %0d",
                             $time, dout.bin, cyc, e.bin, e.cyc);
                end
                compare_sum("r11", dout.r11, e.sums.r11, int'(e.bin));
                compare_sum("r22", dout.r22, e.sums.r22, int'(e.bin));
                compare_sum("r12_re", dout.r12_re, e.sums.r12_re, int'(e.bin));
                compare_sum("r12_im", dout.r12_im, e.sums.r12_im, int'(e.bin));
            end
        end
    end

    // One APB transfer: setup cycle, then one access cycle with pready high.
    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #(QUARTER);
        checks++;
        assert (pready === 1'b1) else begin
            errors++;
            $display("ERR %0t: pready low in the access phase at address 0x%0h", $time, addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
        apb_data_t rdata;
        logic      err;
        apb_access(1'b1, addr, data, rdata, err);
    endtask

    task automatic expect_reg(input apb_addr_t addr, input apb_data_t exp, input string name);
        apb_data_t rdata;
        logic      err;
        apb_access(1'b0, addr, '0, rdata, err);
        checks++;
        assert (rdata == exp && err == 1'b0) else begin
            errors++;
            $display("ERR %0t: %s read 0x%0h with pslverr %0b, expected 0x%0h",
                     $time, name, rdata, err, exp);
        end
    endtask

    // Both a read and a write must be refused.
    task automatic expect_slverr(input apb_addr_t addr);
        apb_data_t rdata;
        logic      rd_err;
        logic      wr_err;
        apb_access(1'b0, addr, '0, rdata, rd_err);
        apb_access(1'b1, addr, 32'h5a, rdata, wr_err);
        checks++;
        assert (rd_err == 1'b1 && wr_err == 1'b1) else begin
            errors++;
            $display("ERR %0t: address 0x%0h gave pslverr %0b on read, %0b on write",
                     $time, addr, rd_err, wr_err);
        end
    endtask

    function automatic ant_sample_s make_sample(input int kind, input int bin);
        ant_sample_s s;
        logic [31:0] r;
        r = next_random();
        s.din1_re = sample_t'(r[15:0]);
        s.din1_im = sample_t'(r[31:16]);
        r = next_random();
        s.din2_re = sample_t'(r[15:0]);
        s.din2_im = sample_t'(r[31:16]);
        if (kind == KIND_FULL) begin
            s.din1_re = r[0] ? FULL_POS : FULL_NEG;
            s.din1_im = r[1] ? FULL_POS : FULL_NEG;
            s.din2_re = r[2] ? FULL_POS : FULL_NEG;
            s.din2_im = r[3] ? FULL_POS : FULL_NEG;
            case (bin)
                0: s = {FULL_NEG, FULL_NEG, FULL_NEG, FULL_NEG};   // Largest r11.
                1: s = {FULL_POS, FULL_POS, FULL_POS, FULL_POS};
                2: s = {FULL_NEG, FULL_NEG, FULL_POS, FULL_POS};   // Largest r22.
                default: ;
            endcase
        end
        return s;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            din_valid   = 1'b0;
            frame_start = 1'b0;
        end
    endtask

    // One frame of VECTOR_LEN samples; the last frame of a period queues its results.
    task automatic send_frame(input int kind, input logic gaps, input logic active,
                              input logic first, input logic last);
        ant_sample_s s;
        cov_ref_s    sum;
        expect_s     e;
        logic [31:0] r;
        int          idle;
        for (int b = 0; b < VECTOR_LEN; b++) begin
            r    = next_random();
            idle = (gaps && r[1:0] == 2'b00) ? int'(r[3:2]) + 1 : 0;
            idle_cycles(idle);
            s = make_sample(kind, b);
            @(negedge clk);
            din         = s;
            din_valid   = 1'b1;
            frame_start = (b == 0);
            if (active) begin
                sum = update_ref(b, sample_products(s), first);
                if (last) begin
                    e.sums = sum;
                    e.bin  = b;
                    e.cyc  = cyc + LATENCY;
                    exp_q.push_back(e);
                end
            end
        end
    endtask

    task automatic send_period(input int frames, input int kind, input logic gaps);
        for (int f = 0; f < frames; f++) begin
            send_frame(kind, gaps, 1'b1, f == 0, f == frames - 1);
        end
        periods_done++;
    endtask

    task automatic drain_outputs(input string what);
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited >= DRAIN_TIMEOUT) begin
                abort_run({"results never arrived after ", what});
            end
            waited++;
            @(negedge clk);
        end
        repeat (SETTLE_CYCLES) @(negedge clk);   // Catches stray outputs.
    endtask

    task automatic expect_outputs(input int start, input int n, input string what);
        checks++;
        assert (out_count - start == n) else begin
            errors++;
            $display("ERR %0t: %s gave %0d outputs, expected %0d", $time, what,
                     out_count - start, n);
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        int errs;
        errs = errors + cmp_errors - err_start;
        tests++;
        $display("Test %0d, %s: %s, %0d errors", tests, name, (errs == 0) ? "ok" : "bad", errs);
    endtask

    initial begin
        int        err_start;
        int        out_start;
        clk         = 1'b0;
        rst_n       = 1'b0;
        din         = '0;
        din_valid   = 1'b0;
        frame_start = 1'b0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        rng_state   = SEED;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Register bank.
        err_start = errors + cmp_errors;
        expect_reg(REG_CTRL, 0, "CTRL after reset");
        expect_reg(REG_ACC_FRAMES, 1, "ACC_FRAMES after reset");
        expect_reg(REG_DONE_COUNT, 0, "DONE_COUNT after reset");
        write_reg(REG_CTRL, 1);
        expect_reg(REG_CTRL, 1, "CTRL");
        write_reg(REG_CTRL, 0);
        expect_reg(REG_CTRL, 0, "CTRL");
        write_reg(REG_ACC_FRAMES, 200);
        expect_reg(REG_ACC_FRAMES, 200, "ACC_FRAMES");
        write_reg(REG_ACC_FRAMES, 0);
        expect_reg(REG_ACC_FRAMES, 1, "ACC_FRAMES written with zero");
        expect_slverr(8'h0c);
        expect_slverr(8'h40);
        end_test("register bank", err_start);

        // Single frame periods; output cycle is checked per bin.
        err_start = errors + cmp_errors;
        out_start = out_count;
        write_reg(REG_ACC_FRAMES, 1);
        write_reg(REG_CTRL, 1);
        send_period(1, KIND_RANDOM, 1'b0);
        idle_cycles(1);
        drain_outputs("single frame");
        expect_outputs(out_start, VECTOR_LEN, "single frame");
        expect_reg(REG_DONE_COUNT, periods_done, "DONE_COUNT after one period");
        end_test("single frame", err_start);

        // Four frames with idle gaps.
        err_start = errors + cmp_errors;
        out_start = out_count;
        write_reg(REG_ACC_FRAMES, 4);
        send_period(4, KIND_RANDOM, 1'b1);
        idle_cycles(1);
        drain_outputs("four frames");
        expect_outputs(out_start, VECTOR_LEN, "four frames");
        expect_reg(REG_DONE_COUNT, periods_done, "DONE_COUNT after four frames");
        end_test("four frames with gaps", err_start);

        // Full scale over the longest period.
        err_start = errors + cmp_errors;
        out_start = out_count;
        write_reg(REG_ACC_FRAMES, 255);
        send_period(255, KIND_FULL, 1'b0);
        idle_cycles(1);
        drain_outputs("full scale");
        expect_outputs(out_start, VECTOR_LEN, "full scale");
        end_test("full scale 255 frames", err_start);

        // Period boundaries, disabled frames and count clear.
        err_start = errors + cmp_errors;
        out_start = out_count;
        write_reg(REG_ACC_FRAMES, 2);
        send_period(2, KIND_RANDOM, 1'b0);
        send_period(2, KIND_RANDOM, 1'b0);
        idle_cycles(1);
        drain_outputs("back to back periods");
        expect_outputs(out_start, 2 * VECTOR_LEN, "back to back periods");
        write_reg(REG_CTRL, 0);
        out_start = out_count;
        send_frame(KIND_RANDOM, 1'b0, 1'b0, 1'b0, 1'b0);
        send_frame(KIND_RANDOM, 1'b0, 1'b0, 1'b0, 1'b0);
        idle_cycles(1);
        drain_outputs("disabled frames");
        expect_outputs(out_start, 0, "disabled frames");
        write_reg(REG_CTRL, 1);
        out_start = out_count;
        send_period(2, KIND_RANDOM, 1'b1);
        idle_cycles(1);
        drain_outputs("period after enable");
        expect_outputs(out_start, VECTOR_LEN, "period after enable");
        expect_reg(REG_DONE_COUNT, periods_done, "DONE_COUNT after three periods");
        write_reg(REG_DONE_COUNT, 32'h1234);
        periods_done = 0;
        expect_reg(REG_DONE_COUNT, periods_done, "DONE_COUNT after clear");
        end_test("period boundaries", err_start);

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks + cmp_checks,
                 errors + cmp_errors);
        if (errors + cmp_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
